// File: axi4_wr_packet_fifo.f
hw/axi4_wr_pkg.sv
hw/cdc_fifo_pkg.sv
hw/async_fifo.sv
hw/aw_issue_ctrl.sv
hw/w_valve.sv
hw/axi4_wr_packet_fifo.sv
testbench/axi_wr_slave_model.sv
testbench/axi4_wr_packet_fifo_tb.sv

// File: testbench/axi4_wr_packet_fifo_tb.sv
// DUT runs PIPE 1 with a 32-entry W FIFO so the held-ready phase can fill it; out clock 7 ns late
`timescale 1ns/1ps
module axi4_wr_packet_fifo_tb;

   localparam int N_BURSTS  = 12;
   // bursts from here on start with out_w_ready held low
   localparam int FILL_FROM = 8;

   typedef struct packed {
      axi4_wr_pkg::aw_beat_t          aw;
      logic [axi4_wr_pkg::DATA_W-1:0] seed;
      logic [1:0]                     resp;
   } burst_row_t;

   logic                  in_axi_aclk = 1'b0;
   logic                  out_axi_aclk = 1'b0;
   logic                  rst_n;
   axi4_wr_pkg::aw_beat_t in_aw;
   logic                  in_aw_valid;
   logic                  in_aw_ready;
   axi4_wr_pkg::w_beat_t  in_w;
   logic                  in_w_valid;
   logic                  in_w_ready;
   axi4_wr_pkg::b_beat_t  in_b;
   logic                  in_b_valid;
   logic                  in_b_ready;
   axi4_wr_pkg::aw_beat_t out_aw;
   logic                  out_aw_valid;
   logic                  out_aw_ready;
   axi4_wr_pkg::w_beat_t  out_w;
   logic                  out_w_valid;
   logic                  out_w_ready;
   axi4_wr_pkg::b_beat_t  out_b;
   logic                  out_b_valid;
   logic                  out_b_ready;

   burst_row_t            rows [N_BURSTS];
   logic [2*N_BURSTS-1:0] resp_list;
   logic                  hold_w = 1'b0;
   logic                  w_sent_all = 1'b0;
   logic                  fill_seen = 1'b0;
   int                    total_beats = 0;
   int                    cycle_limit = 1000;
   int                    cycles = 0;
   int                    aw_seen = 0;
   int                    w_burst = 0;
   int                    w_beat = 0;
   int                    b_seen = 0;

   // 20 ns clocks with the out domain 7 ns behind
   always #10 in_axi_aclk = ~in_axi_aclk;
   always @(in_axi_aclk) out_axi_aclk <= #7 in_axi_aclk;

   axi4_wr_packet_fifo #(
      .AW_DEPTH   (4),
      .DATA_DEPTH (32),
      .PIPE       (1)
   ) u_dut (
      .in_axi_aclk  (in_axi_aclk),
      .out_axi_aclk (out_axi_aclk),
      .rst_n        (rst_n),
      .in_aw        (in_aw),
      .in_aw_valid  (in_aw_valid),
      .in_aw_ready  (in_aw_ready),
      .in_w         (in_w),
      .in_w_valid   (in_w_valid),
      .in_w_ready   (in_w_ready),
      .in_b         (in_b),
      .in_b_valid   (in_b_valid),
      .in_b_ready   (in_b_ready),
      .out_aw       (out_aw),
      .out_aw_valid (out_aw_valid),
      .out_aw_ready (out_aw_ready),
      .out_w        (out_w),
      .out_w_valid  (out_w_valid),
      .out_w_ready  (out_w_ready),
      .out_b        (out_b),
      .out_b_valid  (out_b_valid),
      .out_b_ready  (out_b_ready)
   );

   axi_wr_slave_model #(
      .N_BURSTS (N_BURSTS)
   ) u_slave (
      .clk          (out_axi_aclk),
      .rst_n        (rst_n),
      .hold_w       (hold_w),
      .resp_list    (resp_list),
      .out_aw       (out_aw),
      .out_aw_valid (out_aw_valid),
      .out_aw_ready (out_aw_ready),
      .out_w        (out_w),
      .out_w_valid  (out_w_valid),
      .out_w_ready  (out_w_ready),
      .out_b        (out_b),
      .out_b_valid  (out_b_valid),
      .out_b_ready  (out_b_ready)
   );

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("*** FAILED ***");
      $fatal(1, "run stopped");
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_aw(input axi4_wr_pkg::aw_beat_t got, input axi4_wr_pkg::aw_beat_t exp);
      if (got !== exp) begin
         report_failure($sformatf("FAILED out_aw got 0x%h expected 0x%h", got, exp));
      end
   endtask

   task automatic check_w(input axi4_wr_pkg::w_beat_t got, input axi4_wr_pkg::w_beat_t exp);
      if (got !== exp) begin
         report_failure($sformatf("FAILED out_w got 0x%h expected 0x%h", got, exp));
      end
   endtask

   task automatic check_b(input axi4_wr_pkg::b_beat_t got, input axi4_wr_pkg::b_beat_t exp);
      if (got !== exp) begin
         report_failure($sformatf("FAILED in_b got 0x%h expected 0x%h", got, exp));
      end
   endtask

   function automatic burst_row_t make_row(input logic [3:0] id, input logic [31:0] addr,
                                           input logic [7:0] len, input logic [31:0] seed,
                                           input logic [1:0] resp);
      burst_row_t row;
      row.aw.id   = id;
      row.aw.addr = addr;
      row.aw.len  = len;
      row.seed    = seed;
      row.resp    = resp;
      return row;
   endfunction

   // columns are id, addr, len, data seed and resp
   task automatic load_table();
      rows[0]  = make_row(4'h1, 32'h0000_1000, 8'd0,  32'h1111_0000, 2'd0);
      rows[1]  = make_row(4'h2, 32'h0000_2040, 8'd3,  32'h2222_0000, 2'd0);
      rows[2]  = make_row(4'h3, 32'h0000_3000, 8'd15, 32'h3333_0100, 2'd2);
      rows[3]  = make_row(4'h4, 32'h1000_0000, 8'd7,  32'hA5A5_0000, 2'd0);
      rows[4]  = make_row(4'h5, 32'h1000_0400, 8'd1,  32'h5A5A_FFFE, 2'd3);
      rows[5]  = make_row(4'h6, 32'h2000_0000, 8'd10, 32'h0F0F_0000, 2'd0);
      rows[6]  = make_row(4'h7, 32'h2000_1000, 8'd4,  32'h7777_7770, 2'd1);
      rows[7]  = make_row(4'h8, 32'h3000_0000, 8'd0,  32'h0000_0000, 2'd0);
      // held-ready phase pushes 61 beats at 32 entries
      rows[8]  = make_row(4'h9, 32'h4000_0000, 8'd15, 32'h0BAD_0000, 2'd0);
      rows[9]  = make_row(4'hA, 32'h4000_0100, 8'd15, 32'h1234_5678, 2'd2);
      rows[10] = make_row(4'hB, 32'h4000_0200, 8'd12, 32'h8000_0000, 2'd0);
      rows[11] = make_row(4'hF, 32'h4000_0300, 8'd15, 32'hFFFF_FFF8, 2'd0);
   endtask

   task automatic drive_aw();
      for (int i = 0; i < N_BURSTS; i++) begin
         @(negedge in_axi_aclk);
         in_aw       = rows[i].aw;
         in_aw_valid = 1'b1;
         @(posedge in_axi_aclk);
         while (!in_aw_ready) @(posedge in_axi_aclk);
      end
      @(negedge in_axi_aclk);
      in_aw_valid = 1'b0;
   endtask

   // beat j of a burst carries seed + j
   task automatic drive_w();
      for (int i = 0; i < N_BURSTS; i++) begin
         for (int j = 0; j <= int'(rows[i].aw.len); j++) begin
            @(negedge in_axi_aclk);
            if (i == FILL_FROM && j == 0) begin
               hold_w = 1'b1;
            end
            in_w.data  = rows[i].seed + j;
            in_w.last  = (j == int'(rows[i].aw.len));
            in_w_valid = 1'b1;
            @(posedge in_axi_aclk);
            while (!in_w_ready) @(posedge in_axi_aclk);
         end
      end
      @(negedge in_axi_aclk);
      in_w_valid = 1'b0;
      w_sent_all = 1'b1;
   endtask

   // let the output go again once the W FIFO pushes back
   task automatic release_w_hold();
      wait (hold_w);
      do begin
         @(negedge in_axi_aclk);
      end while (in_w_ready && !w_sent_all);
      if (!in_w_ready) begin
         fill_seen = 1'b1;
      end
      hold_w = 1'b0;
   endtask

   task automatic drive_b_ready();
      while (b_seen < N_BURSTS) begin
         @(negedge in_axi_aclk);
         in_b_ready = ($urandom_range(3) != 0);
      end
      in_b_ready = 1'b0;
   endtask

   // output side order and burst framing
   always @(posedge out_axi_aclk) begin : out_monitor
      axi4_wr_pkg::w_beat_t exp_w;
      if (rst_n) begin
         if (out_w_valid && out_w_ready) begin
            if (w_burst >= aw_seen) begin
               report_failure($sformatf("W beat of burst %0d left before its AW", w_burst));
            end
            exp_w.data = rows[w_burst].seed + w_beat;
            exp_w.last = (w_beat == int'(rows[w_burst].aw.len));
            check_w(out_w, exp_w);
            if (exp_w.last) begin
               w_burst++;
               w_beat = 0;
            end else begin
               w_beat++;
            end
         end
         if (out_aw_valid && out_aw_ready) begin
            if (aw_seen >= N_BURSTS) begin
               report_failure("more AW beats left the output than the table holds");
            end
            check_aw(out_aw, rows[aw_seen].aw);
            aw_seen++;
         end
      end
   end

   // input side responses and run limit
   always @(posedge in_axi_aclk) begin : in_monitor
      axi4_wr_pkg::b_beat_t exp_b;
      cycles++;
      if (cycles >= cycle_limit) begin
         report_failure($sformatf("timeout after %0d cycles, %0d of %0d responses seen",
                                  cycles, b_seen, N_BURSTS));
      end
      if (rst_n && in_b_valid && in_b_ready) begin
         if (b_seen >= N_BURSTS) begin
            report_failure("more B beats returned than bursts were sent");
         end
         exp_b.id   = rows[b_seen].aw.id;
         exp_b.resp = rows[b_seen].resp;
         check_b(in_b, exp_b);
         b_seen++;
      end
   end

   initial begin
      void'($urandom(7));
      rst_n       = 1'b0;
      in_aw       = '0;
      in_aw_valid = 1'b0;
      in_w        = '0;
      in_w_valid  = 1'b0;
      in_b_ready  = 1'b0;
      load_table();
      for (int i = 0; i < N_BURSTS; i++) begin
         total_beats += int'(rows[i].aw.len) + 1;
         resp_list[2*i +: 2] = rows[i].resp;
      end
      cycle_limit = total_beats * 40 + 200;
      repeat (3) @(posedge in_axi_aclk);
      @(negedge in_axi_aclk);
      rst_n = 1'b1;
      @(negedge in_axi_aclk);
      // idle state right after reset
      check_bit("out_aw_valid", out_aw_valid, 1'b0);
      check_bit("out_w_valid", out_w_valid, 1'b0);
      check_bit("in_b_valid", in_b_valid, 1'b0);
      check_bit("in_aw_ready", in_aw_ready, 1'b1);
      check_bit("in_w_ready", in_w_ready, 1'b1);
      check_bit("out_b_ready", out_b_ready, 1'b1);
      fork
         drive_aw();
         drive_w();
         release_w_hold();
         drive_b_ready();
      join
      if (aw_seen == N_BURSTS && w_burst == N_BURSTS && b_seen == N_BURSTS && fill_seen) begin
         $display("*** PASSED ***");
         $finish;
      end else begin
         $display("run ended short: %0d AW, %0d bursts of W, %0d B, W FIFO filled %0d",
                  aw_seen, w_burst, b_seen, fill_seen);
         $display("*** FAILED ***");
         $fatal(1, "run stopped");
      end
   end

endmodule

// File: testbench/axi_wr_slave_model.sv
// output-side write slave for simulation only; random ready, one B per wlast in AW order
`timescale 1ns/1ps
module axi_wr_slave_model #(
   parameter int N_BURSTS = 12
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  hold_w,
   input  logic [2*N_BURSTS-1:0] resp_list,
   input  axi4_wr_pkg::aw_beat_t out_aw,
   input  logic                  out_aw_valid,
   output logic                  out_aw_ready,
   input  axi4_wr_pkg::w_beat_t  out_w,
   input  logic                  out_w_valid,
   output logic                  out_w_ready,
   output axi4_wr_pkg::b_beat_t  out_b,
   output logic                  out_b_valid,
   input  logic                  out_b_ready
);

   // accepted AW beats waiting for their wlast
   axi4_wr_pkg::aw_beat_t aw_q [$];
   // responses waiting to go out
   axi4_wr_pkg::b_beat_t  b_q [$];
   int                    done_count = 0;

   initial begin
      out_aw_ready = 1'b0;
      out_w_ready  = 1'b0;
      out_b_valid  = 1'b0;
      out_b        = '0;
   end

   // capture on the transfer edge
   always @(posedge clk) begin : capture
      axi4_wr_pkg::aw_beat_t head;
      axi4_wr_pkg::b_beat_t  rsp;
      if (rst_n) begin
         if (out_b_valid && out_b_ready) begin
            void'(b_q.pop_front());
         end
         if (out_aw_valid && out_aw_ready) begin
            aw_q.push_back(out_aw);
         end
         // burst ends, answer with its id
         if (out_w_valid && out_w_ready && out_w.last && aw_q.size() > 0 &&
             done_count < N_BURSTS) begin
            head     = aw_q.pop_front();
            rsp.id   = head.id;
            rsp.resp = resp_list[2*done_count +: 2];
            b_q.push_back(rsp);
            done_count++;
         end
      end
   end

   // ready and B driven mid-cycle
   always @(negedge clk) begin
      if (!rst_n) begin
         out_aw_ready = 1'b0;
         out_w_ready  = 1'b0;
         out_b_valid  = 1'b0;
      end else begin
         out_aw_ready = ($urandom_range(3) != 0);
         // hold forces a W stall
         out_w_ready  = !hold_w && ($urandom_range(3) != 0);
         out_b_valid  = (b_q.size() > 0);
         if (b_q.size() > 0) begin
            out_b = b_q[0];
         end
      end
   end

endmodule

// File: hw/axi4_wr_packet_fifo.sv
// one rst_n for both domains, held for several cycles of each clock; no read channels
`timescale 1ns/1ps
module axi4_wr_packet_fifo #(
   parameter int AW_DEPTH   = 4,
   parameter int DATA_DEPTH = 1024,
   parameter int PIPE       = 0
) (
   input  logic                 in_axi_aclk,
   input  logic                 out_axi_aclk,
   input  logic                 rst_n,
   // input side, in_axi_aclk
   input  axi4_wr_pkg::aw_beat_t in_aw,
   input  logic                 in_aw_valid,
   output logic                 in_aw_ready,
   input  axi4_wr_pkg::w_beat_t  in_w,
   input  logic                 in_w_valid,
   output logic                 in_w_ready,
   output axi4_wr_pkg::b_beat_t  in_b,
   output logic                 in_b_valid,
   input  logic                 in_b_ready,
   // output side, out_axi_aclk
   output axi4_wr_pkg::aw_beat_t out_aw,
   output logic                 out_aw_valid,
   input  logic                 out_aw_ready,
   output axi4_wr_pkg::w_beat_t  out_w,
   output logic                 out_w_valid,
   input  logic                 out_w_ready,
   input  axi4_wr_pkg::b_beat_t  out_b,
   input  logic                 out_b_valid,
   output logic                 out_b_ready
);

   // AW fifo head toward the controller
   axi4_wr_pkg::aw_beat_t aw_head;
   logic                  aw_head_valid;
   logic                  aw_pop;

   // W fifo head toward the valve
   axi4_wr_pkg::w_beat_t  w_head;
   logic                  w_head_valid;
   logic                  w_head_ready;

   // controller and valve handshake
   logic                  valve_open;
   logic                  burst_done;

   // address, id and len cross in_ -> out_
   async_fifo #(
      .DEPTH     (AW_DEPTH),
      .payload_t (axi4_wr_pkg::aw_beat_t)
   ) u_aw_fifo (
      .wr_clk   (in_axi_aclk),
      .rd_clk   (out_axi_aclk),
      .rst_n    (rst_n),
      .wr_data  (in_aw),
      .wr_valid (in_aw_valid),
      .wr_ready (in_aw_ready),
      .rd_data  (aw_head),
      .rd_valid (aw_head_valid),
      .rd_ready (aw_pop)
   );

   // deep data store, in_ -> out_
   async_fifo #(
      .DEPTH     (DATA_DEPTH),
      .payload_t (axi4_wr_pkg::w_beat_t)
   ) u_w_fifo (
      .wr_clk   (in_axi_aclk),
      .rd_clk   (out_axi_aclk),
      .rst_n    (rst_n),
      .wr_data  (in_w),
      .wr_valid (in_w_valid),
      .wr_ready (in_w_ready),
      .rd_data  (w_head),
      .rd_valid (w_head_valid),
      .rd_ready (w_head_ready)
   );

   // responses go back out_ -> in_
   async_fifo #(
      .DEPTH     (AW_DEPTH),
      .payload_t (axi4_wr_pkg::b_beat_t)
   ) u_b_fifo (
      .wr_clk   (out_axi_aclk),
      .rd_clk   (in_axi_aclk),
      .rst_n    (rst_n),
      .wr_data  (out_b),
      .wr_valid (out_b_valid),
      .wr_ready (out_b_ready),
      .rd_data  (in_b),
      .rd_valid (in_b_valid),
      .rd_ready (in_b_ready)
   );

   // W fifo valid doubles as data-waiting flag
   aw_issue_ctrl u_aw_issue_ctrl (
      .out_axi_aclk (out_axi_aclk),
      .rst_n        (rst_n),
      .aw_in        (aw_head),
      .aw_in_valid  (aw_head_valid),
      .aw_in_ready  (aw_pop),
      .w_waiting    (w_head_valid),
      .out_aw       (out_aw),
      .out_aw_valid (out_aw_valid),
      .out_aw_ready (out_aw_ready),
      .last_done    (burst_done),
      .open         (valve_open)
   );

   w_valve #(
      .PIPE (PIPE)
   ) u_w_valve (
      .out_axi_aclk (out_axi_aclk),
      .rst_n        (rst_n),
      .open         (valve_open),
      .w_in         (w_head),
      .w_in_valid   (w_head_valid),
      .w_in_ready   (w_head_ready),
      .out_w        (out_w),
      .out_w_valid  (out_w_valid),
      .out_w_ready  (out_w_ready),
      .last_done    (burst_done)
   );

endmodule

// File: hw/w_valve.sv
// PIPE 0 is combinational, PIPE 1 adds a two-entry skid stage; open must hold until last_done
`timescale 1ns/1ps
module w_valve #(
   parameter int PIPE = 0
) (
   input  logic                out_axi_aclk,
   input  logic                rst_n,
   input  logic                open,
   input  axi4_wr_pkg::w_beat_t w_in,
   input  logic                w_in_valid,
   output logic                w_in_ready,
   output axi4_wr_pkg::w_beat_t out_w,
   output logic                out_w_valid,
   input  logic                out_w_ready,
   output logic                last_done
);

   // end of burst seen at the output port
   assign last_done = out_w_valid && out_w_ready && out_w.last;

   if (PIPE == 1) begin : g_pipe
      logic                 take;
      logic                 last_held;
      logic                 main_valid;
      logic                 skid_valid;
      axi4_wr_pkg::w_beat_t main_q;
      axi4_wr_pkg::w_beat_t skid_q;

      // stop after wlast so the next burst cannot slip in before its AW
      assign w_in_ready  = open && !last_held && !skid_valid;
      assign take        = w_in_valid && w_in_ready;
      assign out_w       = main_q;
      assign out_w_valid = main_valid;

      always_ff @(posedge out_axi_aclk or negedge rst_n) begin
         if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            last_held  <= 1'b0;
         end else begin
            if (!main_valid || out_w_ready) begin
               // output slot frees, skid drains first
               main_valid <= skid_valid || take;
               skid_valid <= 1'b0;
            end else if (take) begin
               // output stalled, park beat in skid
               skid_valid <= 1'b1;
            end
            if (take && w_in.last) begin
               last_held <= 1'b1;
            end else if (last_done) begin
               last_held <= 1'b0;
            end
         end
      end

      always_ff @(posedge out_axi_aclk) begin
         if (!main_valid || out_w_ready) begin
            if (skid_valid) begin
               main_q <= skid_q;
            end else if (take) begin
               main_q <= w_in;
            end
         end else if (take) begin
            skid_q <= w_in;
         end
      end
   end else begin : g_comb
      // window gates both directions
      assign out_w       = w_in;
      assign out_w_valid = w_in_valid && open;
      assign w_in_ready  = out_w_ready && open;
   end

endmodule

// File: hw/aw_issue_ctrl.sv
// one burst in flight at a time; AW is issued only once the burst's first W beat is buffered
`timescale 1ns/1ps
module aw_issue_ctrl (
   input  logic                 out_axi_aclk,
   input  logic                 rst_n,
   input  axi4_wr_pkg::aw_beat_t aw_in,
   input  logic                 aw_in_valid,
   output logic                 aw_in_ready,
   input  logic                 w_waiting,
   output axi4_wr_pkg::aw_beat_t out_aw,
   output logic                 out_aw_valid,
   input  logic                 out_aw_ready,
   input  logic                 last_done,
   output logic                 open
);

   typedef enum logic {
      ST_IDLE,
      ST_STREAM
   } state_t;

   state_t state;
   logic   aw_fire;

   // fifo head is held until popped, so it drives the port directly
   assign out_aw  = aw_in;
   assign aw_fire = out_aw_valid && out_aw_ready;

   // pop the AW fifo on the output handshake
   assign aw_in_ready = aw_fire;

   // valve window follows the streaming state
   assign open = (state == ST_STREAM);

   always_ff @(posedge out_axi_aclk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= ST_IDLE;
         out_aw_valid <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (aw_fire) begin
                  // burst accepted, open from next cycle
                  out_aw_valid <= 1'b0;
                  state        <= ST_STREAM;
               end else if (!out_aw_valid && aw_in_valid && w_waiting) begin
                  // address and data both present
                  out_aw_valid <= 1'b1;
               end
            end
            ST_STREAM: begin
               // wait for wlast to leave the valve
               if (last_done) begin
                  state <= ST_IDLE;
               end
            end
            default: begin
               state        <= ST_IDLE;
               out_aw_valid <= 1'b0;
            end
         endcase
      end
   end

endmodule

// File: hw/async_fifo.sv
// DEPTH must be a power of two, at least 2; rst_n must be held long enough for both clocks
`timescale 1ns/1ps
module async_fifo #(
   parameter int  DEPTH     = 4,
   parameter type payload_t = logic [7:0]
) (
   input  logic     wr_clk,
   input  logic     rd_clk,
   input  logic     rst_n,
   input  payload_t wr_data,
   input  logic     wr_valid,
   output logic     wr_ready,
   output payload_t rd_data,
   output logic     rd_valid,
   input  logic     rd_ready
);

   localparam int PTR_W  = cdc_fifo_pkg::ptr_width(DEPTH);
   localparam int ADDR_W = PTR_W - 1;
   localparam int EXT_W  = cdc_fifo_pkg::MAX_PTR_W - PTR_W;

   // storage, no reset
   payload_t mem [DEPTH];

   // write domain
   logic [PTR_W-1:0] wr_bin;
   logic [PTR_W-1:0] wr_bin_next;
   logic [PTR_W-1:0] wr_gray;
   logic [PTR_W-1:0] rd_gray_sync [cdc_fifo_pkg::SYNC_STAGES];
   logic [PTR_W-1:0] rd_bin_w;
   logic [cdc_fifo_pkg::MAX_PTR_W-1:0] wr_gray_wide;
   logic [cdc_fifo_pkg::MAX_PTR_W-1:0] rd_bin_w_wide;
   logic             push;

   // read domain
   logic [PTR_W-1:0] rd_bin;
   logic [PTR_W-1:0] rd_bin_next;
   logic [PTR_W-1:0] rd_gray;
   logic [PTR_W-1:0] wr_gray_sync [cdc_fifo_pkg::SYNC_STAGES];
   logic [PTR_W-1:0] wr_bin_r;
   logic [cdc_fifo_pkg::MAX_PTR_W-1:0] rd_gray_wide;
   logic [cdc_fifo_pkg::MAX_PTR_W-1:0] wr_bin_r_wide;
   logic             pop;

   // full when addresses meet but wrap bits differ
   assign wr_ready = !((wr_bin[ADDR_W-1:0] == rd_bin_w[ADDR_W-1:0]) &&
                       (wr_bin[PTR_W-1] != rd_bin_w[PTR_W-1]));
   assign push        = wr_valid && wr_ready;
   assign wr_bin_next = wr_bin + {{(PTR_W-1){1'b0}}, push};

   // gray code of the next pointer, registered below
   assign wr_gray_wide = cdc_fifo_pkg::bin_to_gray({{EXT_W{1'b0}}, wr_bin_next});

   // read pointer as seen in the write domain
   assign rd_bin_w_wide =
      cdc_fifo_pkg::gray_to_bin({{EXT_W{1'b0}}, rd_gray_sync[cdc_fifo_pkg::SYNC_STAGES-1]});
   assign rd_bin_w      = rd_bin_w_wide[PTR_W-1:0];

   always_ff @(posedge wr_clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_bin  <= '0;
         wr_gray <= '0;
         for (int i = 0; i < cdc_fifo_pkg::SYNC_STAGES; i++) begin
            rd_gray_sync[i] <= '0;
         end
      end else begin
         wr_bin          <= wr_bin_next;
         wr_gray         <= wr_gray_wide[PTR_W-1:0];
         rd_gray_sync[0] <= rd_gray;
         for (int i = 1; i < cdc_fifo_pkg::SYNC_STAGES; i++) begin
            rd_gray_sync[i] <= rd_gray_sync[i-1];
         end
      end
   end

   always_ff @(posedge wr_clk) begin
      if (push) begin
         mem[wr_bin[ADDR_W-1:0]] <= wr_data;
      end
   end

   // empty when both pointers match exactly
   assign rd_valid    = (rd_bin != wr_bin_r);
   assign pop         = rd_valid && rd_ready;
   assign rd_bin_next = rd_bin + {{(PTR_W-1){1'b0}}, pop};

   assign rd_gray_wide = cdc_fifo_pkg::bin_to_gray({{EXT_W{1'b0}}, rd_bin_next});

   // write pointer as seen in the read domain
   assign wr_bin_r_wide =
      cdc_fifo_pkg::gray_to_bin({{EXT_W{1'b0}}, wr_gray_sync[cdc_fifo_pkg::SYNC_STAGES-1]});
   assign wr_bin_r      = wr_bin_r_wide[PTR_W-1:0];

   always_ff @(posedge rd_clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_bin  <= '0;
         rd_gray <= '0;
         for (int i = 0; i < cdc_fifo_pkg::SYNC_STAGES; i++) begin
            wr_gray_sync[i] <= '0;
         end
      end else begin
         rd_bin          <= rd_bin_next;
         rd_gray         <= rd_gray_wide[PTR_W-1:0];
         wr_gray_sync[0] <= wr_gray;
         for (int i = 1; i < cdc_fifo_pkg::SYNC_STAGES; i++) begin
            wr_gray_sync[i] <= wr_gray_sync[i-1];
         end
      end
   end

   // head entry shown without a read register
   assign rd_data = mem[rd_bin[ADDR_W-1:0]];

endmodule

// File: hw/cdc_fifo_pkg.sv
// crossing FIFO helpers; depths must be powers of two and pointers at most MAX_PTR_W bits
package cdc_fifo_pkg;

   // flops per synchronizer chain
   localparam int SYNC_STAGES = 2;

   // widest pointer the code helpers handle
   localparam int MAX_PTR_W = 32;

   // one extra bit over the address tells full from empty
   function automatic int ptr_width(input int depth);
      return $clog2(depth) + 1;
   endfunction

   // binary to reflected gray
   function automatic logic [MAX_PTR_W-1:0] bin_to_gray(input logic [MAX_PTR_W-1:0] bin);
      return bin ^ (bin >> 1);
   endfunction

   // gray back to binary, msb first
   function automatic logic [MAX_PTR_W-1:0] gray_to_bin(input logic [MAX_PTR_W-1:0] gray);
      logic [MAX_PTR_W-1:0] bin;
      bin[MAX_PTR_W-1] = gray[MAX_PTR_W-1];
      for (int i = MAX_PTR_W - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

// File: hw/axi4_wr_pkg.sv
// full-width INCR write bursts only; no strobes, no user bits, len holds beats minus one
package axi4_wr_pkg;

   // channel field widths
   localparam int ID_W   = 4;
   localparam int ADDR_W = 32;
   localparam int LEN_W  = 8;
   localparam int DATA_W = 32;

   // one write-address request, 44 bits
   // id sits in the top bits
   typedef struct packed {
      logic [ID_W-1:0]   id;
      logic [ADDR_W-1:0] addr;
      logic [LEN_W-1:0]  len;
   } aw_beat_t;

   // one data beat, 33 bits
   // every byte lane is written
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
   } w_beat_t;

   // one write response, 6 bits
   // resp uses the AXI encoding, 0 is OKAY
   typedef struct packed {
      logic [ID_W-1:0] id;
      logic [1:0]      resp;
   } b_beat_t;

endpackage
